// ==== source/hart_params.svh ====
////////////////////////////////////////////////////////////
// sizing macros shared by every part of the hart
// RV32 only so XLEN has to stay at 32
// the reset vector must be word aligned
////////////////////////////////////////////////////////////
`ifndef HART_PARAMS_SVH
`define HART_PARAMS_SVH

// data and address width in bits
`define XLEN 32

// integer registers including x0
`define NUM_REGS 32

// first fetch address after reset
`define RESET_VECTOR 32'h0000_0000

`endif

// ==== source/hartPkg.sv ====
////////////////////////////////////////////////////////////
// shared types of the hart
// widths follow the macros in hart_params.svh
////////////////////////////////////////////////////////////
`include "hart_params.svh"

package hartPkg;

  // one data or address word
  typedef logic [`XLEN-1:0] wordT;

  // index into the integer register file
  typedef logic [$clog2(`NUM_REGS)-1:0] regAddrT;

  // ALU operations
  // passB hands operand B straight through for LUI
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluPassB
  } aluOpT;

  // data memory operation carried down to M
  // only full words are moved
  typedef enum logic [1:0] {
    memNone,
    memLoad,
    memStore
  } memOpT;

endpackage

// ==== source/fetchStage.sv ====
////////////////////////////////////////////////////////////
// program counter of the fetch stage
// instruction memory is outside and answers in the same cycle
// static not-taken prediction so only Execute redirects
////////////////////////////////////////////////////////////
`include "hart_params.svh"

module fetchStage (
  input  logic          clk,
  input  logic          rst,
  input  logic          stallF,
  input  logic          redirectE,
  input  hartPkg::wordT targetE,
  output hartPkg::wordT pcF
);
  import hartPkg::*;

  // sequential successor
  wordT pcPlus4F;

  assign pcPlus4F = pcF + wordT'(4);

  // redirect beats stall
  // Execute only raises redirectE on a cycle it advances
  always_ff @(posedge clk) begin
    if (rst) begin
      pcF <= `RESET_VECTOR;
    end else if (redirectE) begin
      pcF <= targetE;
    end else if (!stallF) begin
      pcF <= pcPlus4F;
    end
  end

endmodule

// ==== source/decodeStage.sv ====
////////////////////////////////////////////////////////////
// decode stage with the integer register file
// unknown opcodes and funct3 values become no-ops
// rs fields are reported even when an instruction has none
////////////////////////////////////////////////////////////
`include "hart_params.svh"

module decodeStage (
  input  logic             clk,
  input  logic             rst,
  input  logic             stallD,
  input  logic             flushD,
  input  logic             stallE,
  input  logic             flushE,
  input  logic             regWriteM,
  input  hartPkg::wordT    instrF,
  input  hartPkg::wordT    pcF,
  input  hartPkg::wordT    resultM,
  input  hartPkg::regAddrT rdM,
  output hartPkg::regAddrT rs1D,
  output hartPkg::regAddrT rs2D,
  output hartPkg::wordT    pcE,
  output hartPkg::wordT    srcAE,
  output hartPkg::wordT    srcBE,
  output hartPkg::wordT    rs2ValE,
  output hartPkg::wordT    immE,
  output hartPkg::regAddrT rs1E,
  output hartPkg::regAddrT rs2E,
  output hartPkg::regAddrT rdE,
  output hartPkg::aluOpT   aluOpE,
  output hartPkg::memOpT   memOpE,
  output logic             regWriteE,
  output logic             useImmE,
  output logic             branchE,
  output logic             branchNeE,
  output logic             jumpE
);
  import hartPkg::*;

  // addi x0, x0, 0
  localparam wordT nopInstr = 32'h0000_0013;
  localparam logic [6:0] opReg    = 7'b0110011;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;

  wordT    instrD;
  wordT    pcD;
  wordT    immI;
  wordT    immS;
  wordT    immB;
  wordT    immJ;
  wordT    immU;
  wordT    immD;
  wordT    rs1ValD;
  wordT    rs2ValD;
  wordT    regs [`NUM_REGS];
  regAddrT rdD;
  aluOpT   aluOpD;
  memOpT   memOpD;
  logic    regWriteD;
  logic    useImmD;
  logic    branchD;
  logic    branchNeD;
  logic    jumpD;
  logic [6:0] opcode;
  logic [2:0] funct3;

  // F/D register
  // a flush drops the wrong-path fetch to a no-op
  always_ff @(posedge clk) begin
    if (rst || flushD) begin
      instrD <= nopInstr;
    end else if (!stallD) begin
      instrD <= instrF;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallD) begin
      pcD <= pcF;
    end
  end

  assign opcode = instrD[6:0];
  assign funct3 = instrD[14:12];
  assign rdD    = instrD[11:7];
  assign rs1D   = instrD[19:15];
  assign rs2D   = instrD[24:20];

  // immediates for each format with the sign taken from bit 31
  assign immI = {{(`XLEN-12){instrD[31]}}, instrD[31:20]};
  assign immS = {{(`XLEN-12){instrD[31]}}, instrD[31:25], instrD[11:7]};
  assign immB = {{(`XLEN-13){instrD[31]}}, instrD[31], instrD[7],
                 instrD[30:25], instrD[11:8], 1'b0};
  assign immJ = {{(`XLEN-21){instrD[31]}}, instrD[31], instrD[19:12],
                 instrD[20], instrD[30:21], 1'b0};
  assign immU = {instrD[31:12], 12'b0};

  ////////////////////////////////////////////////////////////
  // control decode
  always_comb begin
    aluOpD    = aluAdd;
    memOpD    = memNone;
    regWriteD = 1'b0;
    useImmD   = 1'b0;
    branchD   = 1'b0;
    branchNeD = 1'b0;
    jumpD     = 1'b0;
    immD      = immI;
    case (opcode)
      opReg: begin
        regWriteD = 1'b1;
        case (funct3)
          3'b000:  aluOpD = instrD[30] ? aluSub : aluAdd;
          3'b010:  aluOpD = aluSlt;
          3'b100:  aluOpD = aluXor;
          3'b110:  aluOpD = aluOr;
          3'b111:  aluOpD = aluAnd;
          default: regWriteD = 1'b0;
        endcase
      end
      opImm: begin
        // only ADDI
        regWriteD = (funct3 == 3'b000);
        useImmD   = 1'b1;
      end
      opLui: begin
        aluOpD    = aluPassB;
        regWriteD = 1'b1;
        useImmD   = 1'b1;
        immD      = immU;
      end
      opLoad: begin
        // only LW
        if (funct3 == 3'b010) begin
          memOpD    = memLoad;
          regWriteD = 1'b1;
        end
        useImmD = 1'b1;
      end
      opStore: begin
        if (funct3 == 3'b010) begin
          memOpD = memStore;
        end
        useImmD = 1'b1;
        immD    = immS;
      end
      opBranch: begin
        // BEQ and BNE differ in funct3 bit 0
        branchD   = (funct3[2:1] == 2'b00);
        branchNeD = funct3[0];
        immD      = immB;
      end
      opJal: begin
        jumpD     = 1'b1;
        regWriteD = 1'b1;
        immD      = immJ;
      end
      default: begin
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // register file
  // a same-cycle writeback passes straight to the readers
  assign rs1ValD = (rs1D == '0) ? '0 :
                   (regWriteM && rdM == rs1D) ? resultM : regs[rs1D];
  assign rs2ValD = (rs2D == '0) ? '0 :
                   (regWriteM && rdM == rs2D) ? resultM : regs[rs2D];

  always_ff @(posedge clk) begin
    if (regWriteM && rdM != '0) begin
      regs[rdM] <= resultM;
    end
  end

  ////////////////////////////////////////////////////////////
  // D/E register
  // flushE empties only the control bits
  always_ff @(posedge clk) begin
    if (rst || flushE) begin
      regWriteE <= 1'b0;
      memOpE    <= memNone;
      branchE   <= 1'b0;
      jumpE     <= 1'b0;
    end else if (!stallE) begin
      regWriteE <= regWriteD;
      memOpE    <= memOpD;
      branchE   <= branchD;
      jumpE     <= jumpD;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallE) begin
      pcE       <= pcD;
      srcAE     <= rs1ValD;
      srcBE     <= useImmD ? immD : rs2ValD;
      rs2ValE   <= rs2ValD;
      immE      <= immD;
      rs1E      <= rs1D;
      rs2E      <= rs2D;
      rdE       <= rdD;
      aluOpE    <= aluOpD;
      useImmE   <= useImmD;
      branchNeE <= branchNeD;
    end
  end

endmodule

// ==== source/executeStage.sv ====
////////////////////////////////////////////////////////////
// execute stage with forwarding from M
// branches and JAL resolve here with a two-cycle penalty
////////////////////////////////////////////////////////////
module executeStage (
  input  logic             clk,
  input  logic             rst,
  input  logic             stallE,
  input  logic             flushM,
  input  logic             regWriteM,
  input  hartPkg::wordT    pcE,
  input  hartPkg::wordT    srcAE,
  input  hartPkg::wordT    srcBE,
  input  hartPkg::wordT    rs2ValE,
  input  hartPkg::wordT    immE,
  input  hartPkg::regAddrT rs1E,
  input  hartPkg::regAddrT rs2E,
  input  hartPkg::regAddrT rdE,
  input  hartPkg::aluOpT   aluOpE,
  input  hartPkg::memOpT   memOpE,
  input  logic             regWriteE,
  input  logic             useImmE,
  input  logic             branchE,
  input  logic             branchNeE,
  input  logic             jumpE,
  input  hartPkg::regAddrT rdM,
  input  hartPkg::wordT    resultM,
  output logic             redirectE,
  output hartPkg::wordT    targetE,
  output hartPkg::wordT    aluOutM,
  output hartPkg::wordT    storeDataM,
  output hartPkg::wordT    linkM,
  output hartPkg::regAddrT rdM2,
  output hartPkg::memOpT   memOpM,
  output logic             regWriteMOut,
  output logic             isJumpM
);
  import hartPkg::*;

  wordT fwdAE;
  wordT fwdBE;
  wordT aluBE;
  wordT aluResultE;
  wordT linkE;
  logic fwdSelAE;
  logic fwdSelBE;
  logic takenE;

  ////////////////////////////////////////////////////////////
  // operand forwarding
  // x0 never forwards
  assign fwdSelAE = regWriteM && (rdM != '0) && (rdM == rs1E);
  assign fwdSelBE = regWriteM && (rdM != '0) && (rdM == rs2E);
  assign fwdAE    = fwdSelAE ? resultM : srcAE;
  assign fwdBE    = fwdSelBE ? resultM : rs2ValE;

  // immediate forms already carry the immediate in srcBE
  assign aluBE = useImmE ? srcBE : fwdBE;

  always_comb begin
    case (aluOpE)
      aluAdd:  aluResultE = fwdAE + aluBE;
      aluSub:  aluResultE = fwdAE - aluBE;
      aluAnd:  aluResultE = fwdAE & aluBE;
      aluOr:   aluResultE = fwdAE | aluBE;
      aluXor:  aluResultE = fwdAE ^ aluBE;
      aluSlt:  aluResultE = wordT'($signed(fwdAE) < $signed(aluBE));
      default: aluResultE = aluBE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // branch and jump resolution
  // BNE inverts the equality test
  assign takenE    = jumpE || (branchE && ((fwdAE == fwdBE) != branchNeE));
  // held instructions wait until the bus releases E
  assign redirectE = takenE && !stallE;
  assign targetE   = pcE + immE;
  assign linkE     = pcE + wordT'(4);

  ////////////////////////////////////////////////////////////
  // E/M register
  // held for the whole of a bus access
  always_ff @(posedge clk) begin
    if (rst || flushM) begin
      memOpM       <= memNone;
      regWriteMOut <= 1'b0;
      isJumpM      <= 1'b0;
    end else if (!stallE) begin
      memOpM       <= memOpE;
      regWriteMOut <= regWriteE;
      isJumpM      <= jumpE;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallE) begin
      aluOutM    <= aluResultE;
      storeDataM <= fwdBE;
      linkM      <= linkE;
      rdM2       <= rdE;
    end
  end

endmodule

// ==== source/memStage.sv ====
////////////////////////////////////////////////////////////
// APB master for word loads and stores plus writeback select
// no pslverr and no byte strobes
// the E/M register must hold its payload while busM is high
////////////////////////////////////////////////////////////
module memStage (
  input  logic             clk,
  input  logic             rst,
  input  hartPkg::wordT    aluOutM,
  input  hartPkg::wordT    storeDataM,
  input  hartPkg::wordT    linkM,
  input  hartPkg::memOpT   memOpM,
  input  logic             isJumpM,
  input  logic             regWriteMIn,
  input  hartPkg::regAddrT rdMIn,
  input  hartPkg::wordT    prdata,
  input  logic             pready,
  output hartPkg::wordT    paddr,
  output hartPkg::wordT    pwdata,
  output logic             psel,
  output logic             penable,
  output logic             pwrite,
  output logic             busM,
  output logic             regWriteM,
  output hartPkg::regAddrT rdM,
  output hartPkg::wordT    resultM
);
  import hartPkg::*;

  // low in setup and high in access
  logic accessPhase;
  logic memActive;
  logic doneM;

  assign memActive = (memOpM != memNone);
  assign doneM     = accessPhase && pready;

  ////////////////////////////////////////////////////////////
  // setup then access sequencer
  always_ff @(posedge clk) begin
    if (rst || doneM) begin
      accessPhase <= 1'b0;
    end else if (memActive) begin
      accessPhase <= 1'b1;
    end
  end

  // address and data come from the held E/M register
  // so they stay stable until completion
  assign psel    = memActive;
  assign penable = accessPhase;
  assign pwrite  = (memOpM == memStore);
  assign paddr   = aluOutM;
  assign pwdata  = storeDataM;

  // the whole pipe waits until the access phase sees pready
  assign busM = memActive && !doneM;

  ////////////////////////////////////////////////////////////
  // writeback
  // a load writes only in its completion cycle
  assign regWriteM = regWriteMIn && ((memOpM != memLoad) || doneM);
  assign rdM       = rdMIn;

  always_comb begin
    if (memOpM == memLoad) begin
      resultM = prdata;
    end else if (isJumpM) begin
      resultM = linkM;
    end else begin
      resultM = aluOutM;
    end
  end

endmodule

// ==== source/hazardUnit.sv ====
////////////////////////////////////////////////////////////
// stall and flush control for the whole pipeline
// bus wait outranks redirect and load-use
////////////////////////////////////////////////////////////
module hazardUnit (
  input  hartPkg::regAddrT rs1D,
  input  hartPkg::regAddrT rs2D,
  input  hartPkg::regAddrT rdE,
  input  hartPkg::memOpT   memOpE,
  input  logic             redirectE,
  input  logic             busM,
  output logic             stallF,
  output logic             stallD,
  output logic             stallE,
  output logic             flushD,
  output logic             flushE,
  output logic             flushM
);
  import hartPkg::*;

  logic loadUseD;

  // load in E feeding the instruction in D
  // x0 never needs the bubble
  assign loadUseD = (memOpE == memLoad) && (rdE != '0) &&
                    ((rdE == rs1D) || (rdE == rs2D));

  // a bus wait freezes everything
  // load-use holds only F and D
  assign stallF = busM || loadUseD;
  assign stallD = busM || loadUseD;
  assign stallE = busM;

  // no flush while frozen
  // a flush then would kill a held instruction
  assign flushD = !busM && redirectE;
  assign flushE = !busM && (redirectE || loadUseD);

  // nothing is killed once it has left E
  assign flushM = 1'b0;

endmodule

// ==== source/pipelinedHart.sv ====
////////////////////////////////////////////////////////////
// four-stage RV32I hart with APB data port
// instruction word must arrive in the same cycle as pcF
////////////////////////////////////////////////////////////
module pipelinedHart (
  input  logic          clk,
  input  logic          rst,
  output hartPkg::wordT pcF,
  input  hartPkg::wordT instrF,
  output hartPkg::wordT paddr,
  output hartPkg::wordT pwdata,
  output logic          psel,
  output logic          penable,
  output logic          pwrite,
  input  hartPkg::wordT prdata,
  input  logic          pready
);
  import hartPkg::*;

  // global stall and flush
  logic    stallF;
  logic    stallD;
  logic    stallE;
  logic    flushD;
  logic    flushE;
  logic    flushM;

  // redirect from E
  logic    redirectE;
  wordT    targetE;

  // decode to execute
  regAddrT rs1D;
  regAddrT rs2D;
  wordT    pcE;
  wordT    srcAE;
  wordT    srcBE;
  wordT    rs2ValE;
  wordT    immE;
  regAddrT rs1E;
  regAddrT rs2E;
  regAddrT rdE;
  aluOpT   aluOpE;
  memOpT   memOpE;
  logic    regWriteE;
  logic    useImmE;
  logic    branchE;
  logic    branchNeE;
  logic    jumpE;

  // E/M register contents
  wordT    aluOutM;
  wordT    storeDataM;
  wordT    linkM;
  regAddrT rdPipeM;
  memOpT   memOpM;
  logic    regWritePipeM;
  logic    isJumpM;

  // writeback and bus status
  logic    busM;
  logic    regWriteM;
  regAddrT rdM;
  wordT    resultM;

  // program counter
  fetchStage ifu (.*);

  // decoder, register file and D/E register
  decodeStage idu (.*);

  // ALU, forwarding, branch resolution and E/M register
  executeStage ieu (.rdM2(rdPipeM), .regWriteMOut(regWritePipeM), .*);

  // APB data access and writeback select
  memStage ebu (.rdMIn(rdPipeM), .regWriteMIn(regWritePipeM), .*);

  hazardUnit hzu (.*);

endmodule

// ==== testbench/apbMemModel.sv ====
////////////////////////////////////////////////////////////
// APB slave memory of 256 words with paddr bits above 9 ignored
// 0 to 3 random wait states per transfer from seed 54851
// a protocol fault is described and flagged on protocolFault
////////////////////////////////////////////////////////////
module apbMemModel (
  input  logic          clk,
  input  logic          rst,
  input  hartPkg::wordT paddr,
  input  hartPkg::wordT pwdata,
  input  logic          psel,
  input  logic          penable,
  input  logic          pwrite,
  output hartPkg::wordT prdata,
  output logic          pready,
  output logic          protocolFault
);
  import hartPkg::*;

  localparam int   depth   = 256;
  // fill key mixed into every word so each address holds its own value
  localparam wordT fillKey = 32'hC001_D00D;

  wordT   mem [depth];
  wordT   heldAddr;
  wordT   heldData;
  logic   heldWrite;
  // setup seen and completion still ahead
  logic   inTransfer;
  integer seed;
  integer waitLeft;
  integer waitPick;

  task automatic reportFault(input string what);
    $display("APB protocol error at time %0t: %s", $time, what);
    protocolFault = 1'b1;
  endtask

  initial begin
    int i;
    seed          = 54851;
    pready        = 1'b0;
    protocolFault = 1'b0;
    inTransfer    = 1'b0;
    waitLeft      = 0;
    for (i = 0; i < depth; i++) begin
      mem[i] = wordT'(i * 4) ^ fillKey;
    end
  end

  // read data follows the address, which holds for the whole transfer
  assign prdata = mem[paddr[9:2]];

  ////////////////////////////////////////////////////////////
  // protocol checks and wait-state sequencing
  always @(posedge clk) begin
    if (rst) begin
      pready     <= 1'b0;
      inTransfer <= 1'b0;
      waitLeft   <= 0;
    end else begin
      if (penable && !psel) begin
        reportFault("penable is high while psel is low");
      end
      if (inTransfer && !(psel && penable)) begin
        reportFault("access phase missing or dropped before pready");
      end
      if (!inTransfer && penable) begin
        reportFault("penable is high without a setup cycle before it");
      end
      if (inTransfer && (paddr !== heldAddr || pwrite !== heldWrite ||
                         (heldWrite && pwdata !== heldData))) begin
        reportFault("address, direction or write data changed during a transfer");
      end
      if (psel && !penable) begin
        // setup cycle picks the wait states of this transfer
        heldAddr   <= paddr;
        heldData   <= pwdata;
        heldWrite  <= pwrite;
        inTransfer <= 1'b1;
        waitPick = $unsigned($random(seed)) % 4;
        waitLeft   <= waitPick;
        pready     <= (waitPick == 0);
      end else if (psel && penable) begin
        if (pready) begin
          inTransfer <= 1'b0;
          pready     <= 1'b0;
          if (pwrite) begin
            mem[paddr[9:2]] <= pwdata;
          end
        end else begin
          waitLeft <= waitLeft - 1;
          if (waitLeft == 1) begin
            pready <= 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== testbench/pipelinedHartTb.sv ====
////////////////////////////////////////////////////////////
// testbench of the pipelined hart with a same-cycle program ROM
// stores are checked by order and value, never by cycle count
// the program ends in a JAL to itself
////////////////////////////////////////////////////////////
`include "hart_params.svh"

module pipelinedHartTb;
  import hartPkg::*;

  localparam int   romWords      = 64;
  localparam int   progLen       = 36;
  localparam int   numStores     = 12;
  // 12 stores plus 2 loads on the executed path
  localparam int   numMemOps     = 14;
  localparam int   resetCycles   = 4;
  localparam int   tailCycles    = 20;
  localparam int   timeoutCycles = progLen * 8 + numMemOps * 4 + resetCycles + tailCycles;
  localparam wordT nop           = 32'h0000_0013;
  localparam logic [6:0] opImm   = 7'b0010011;
  localparam logic [6:0] opLoad  = 7'b0000011;

  logic clk;
  logic rst;
  wordT pcF;
  wordT instrF;
  wordT paddr;
  wordT pwdata;
  logic psel;
  logic penable;
  logic pwrite;
  wordT prdata;
  logic pready;
  logic protocolFault;

  wordT rom [romWords];
  wordT expAddr [numStores];
  wordT expData [numStores];
  int   cycleCount;

  ////////////////////////////////////////////////////////////
  // instruction encoders with operands in assembly order
  function automatic wordT regOp(input logic [6:0] funct7, input logic [2:0] funct3,
                                 input regAddrT rd, input regAddrT rs1, input regAddrT rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  function automatic wordT immOp(input logic [6:0] opcode, input logic [2:0] funct3,
                                 input regAddrT rd, input regAddrT rs1,
                                 input logic [11:0] imm);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  // sw rs2, imm(rs1)
  function automatic wordT storeOp(input regAddrT rs2, input regAddrT rs1,
                                   input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic wordT branchOp(input logic [2:0] funct3, input regAddrT rs1,
                                    input regAddrT rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic wordT jalOp(input regAddrT rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic wordT luiOp(input regAddrT rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  ////////////////////////////////////////////////////////////
  // failure reporting and compare tasks
  task automatic abortRun();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkWord(input string name, input wordT got, input wordT exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      abortRun();
    end
  endtask

  // sampled at the falling edge before the write completes on the rising edge
  task automatic waitWrite();
    @(negedge clk);
    while (!(psel && penable && pready && pwrite)) begin
      @(negedge clk);
    end
  endtask

  task automatic loadProgram();
    int k;
    for (k = 0; k < romWords; k++) begin
      rom[k] = nop;
    end
    // dependent arithmetic chain
    rom[0]  = immOp(opImm, 3'b000, 5'd1, 5'd0, 12'd5);
    rom[1]  = immOp(opImm, 3'b000, 5'd2, 5'd1, 12'd7);
    rom[2]  = regOp(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
    rom[3]  = storeOp(5'd3, 5'd0, 12'h100);
    rom[4]  = regOp(7'h20, 3'b000, 5'd4, 5'd1, 5'd2);
    rom[5]  = storeOp(5'd4, 5'd0, 12'h104);
    rom[6]  = regOp(7'h00, 3'b111, 5'd5, 5'd2, 5'd4);
    rom[7]  = storeOp(5'd5, 5'd0, 12'h108);
    rom[8]  = regOp(7'h00, 3'b110, 5'd6, 5'd5, 5'd1);
    rom[9]  = storeOp(5'd6, 5'd0, 12'h10C);
    rom[10] = regOp(7'h00, 3'b100, 5'd7, 5'd6, 5'd2);
    rom[11] = storeOp(5'd7, 5'd0, 12'h110);
    // signed compare where 5 < -7 is false
    rom[12] = regOp(7'h00, 3'b010, 5'd8, 5'd1, 5'd4);
    rom[13] = storeOp(5'd8, 5'd0, 12'h114);
    rom[14] = luiOp(5'd9, 20'h12345);
    rom[15] = immOp(opImm, 3'b000, 5'd9, 5'd9, 12'h678);
    rom[16] = storeOp(5'd9, 5'd0, 12'h118);
    // load-use through rs1 and then through the store data
    rom[17] = immOp(opLoad, 3'b010, 5'd10, 5'd0, 12'h200);
    rom[18] = regOp(7'h00, 3'b000, 5'd11, 5'd10, 5'd10);
    rom[19] = storeOp(5'd11, 5'd0, 12'h11C);
    rom[20] = immOp(opLoad, 3'b010, 5'd12, 5'd0, 12'h204);
    rom[21] = storeOp(5'd12, 5'd0, 12'h120);
    // control flow with stores to 0x1Fx in skipped slots
    rom[22] = branchOp(3'b000, 5'd1, 5'd2, 13'd8);
    rom[23] = storeOp(5'd1, 5'd0, 12'h124);
    rom[24] = branchOp(3'b001, 5'd1, 5'd2, 13'd8);
    rom[25] = storeOp(5'd2, 5'd0, 12'h1F0);
    rom[26] = branchOp(3'b000, 5'd3, 5'd3, 13'd12);
    rom[27] = storeOp(5'd3, 5'd0, 12'h1F4);
    rom[28] = storeOp(5'd3, 5'd0, 12'h1F8);
    rom[29] = branchOp(3'b001, 5'd1, 5'd1, 13'd8);
    rom[30] = storeOp(5'd2, 5'd0, 12'h128);
    rom[31] = jalOp(5'd13, 21'd12);
    rom[32] = storeOp(5'd1, 5'd0, 12'h1FC);
    rom[33] = storeOp(5'd1, 5'd0, 12'h1FC);
    rom[34] = storeOp(5'd13, 5'd0, 12'h12C);
    // spin here for the rest of the run
    rom[35] = jalOp(5'd0, 21'd0);
  endtask

  // RV32I results worked out by hand
  // loaded words are address xor 0xC001D00D
  task automatic loadExpected();
    expAddr[0]  = 32'h100;
    expData[0]  = 32'h0000_0011;
    expAddr[1]  = 32'h104;
    expData[1]  = 32'hFFFF_FFF9;
    expAddr[2]  = 32'h108;
    expData[2]  = 32'h0000_0008;
    expAddr[3]  = 32'h10C;
    expData[3]  = 32'h0000_000D;
    expAddr[4]  = 32'h110;
    expData[4]  = 32'h0000_0001;
    expAddr[5]  = 32'h114;
    expData[5]  = 32'h0000_0000;
    expAddr[6]  = 32'h118;
    expData[6]  = 32'h1234_5678;
    // 2 * 0xC001D20D truncated to 32 bits
    expAddr[7]  = 32'h11C;
    expData[7]  = 32'h8003_A41A;
    expAddr[8]  = 32'h120;
    expData[8]  = 32'hC001_D209;
    expAddr[9]  = 32'h124;
    expData[9]  = 32'h0000_0005;
    expAddr[10] = 32'h128;
    expData[10] = 32'h0000_000C;
    // link of the JAL at 0x7C
    expAddr[11] = 32'h12C;
    expData[11] = 32'h0000_0080;
  endtask

  ////////////////////////////////////////////////////////////
  // DUT, data memory and program ROM
  pipelinedHart DUT (.*);

  apbMemModel dataMem (.*);

  assign instrF = (pcF < romWords * 4) ? rom[pcF[7:2]] : nop;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("timeout: the expected stores did not finish within %0d cycles",
               timeoutCycles);
      abortRun();
    end
  end

  always @(posedge protocolFault) begin
    abortRun();
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  initial begin
    int   i;
    logic extra;
    wordT extraAddr;
    rst        = 1'b1;
    cycleCount = 0;
    extra      = 1'b0;
    extraAddr  = '0;
    loadProgram();
    loadExpected();
    // last pass covers the first cycle after release
    for (i = 0; i < resetCycles; i++) begin
      @(posedge clk);
      if (i == resetCycles - 1) begin
        rst <= 1'b0;
      end
      @(negedge clk);
      checkWord("pcF", pcF, `RESET_VECTOR);
      checkBit("psel", psel, 1'b0);
      checkBit("penable", penable, 1'b0);
    end
    for (i = 0; i < numStores; i++) begin
      waitWrite();
      checkWord("paddr", paddr, expAddr[i]);
      checkWord("pwdata", pwdata, expData[i]);
    end
    // no store may follow once the program spins
    for (i = 0; i < tailCycles; i++) begin
      @(negedge clk);
      if (psel && pwrite && !extra) begin
        extra     = 1'b1;
        extraAddr = paddr;
      end
    end
    if (!extra) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("a store to %h appeared after the last expected store", extraAddr);
      abortRun();
    end
  end

endmodule

// ==== miniHart.f ====
+incdir+source
source/hartPkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memStage.sv
source/hazardUnit.sv
source/pipelinedHart.sv
testbench/apbMemModel.sv
testbench/pipelinedHartTb.sv

// ==== Bender.yml ====
package:
  name: miniHart

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/hartPkg.sv
      - source/fetchStage.sv
      - source/decodeStage.sv
      - source/executeStage.sv
      - source/memStage.sv
      - source/hazardUnit.sv
      - source/pipelinedHart.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/apbMemModel.sv
      - testbench/pipelinedHartTb.sv
